//--- aes/aes_cipher_core.sv
/*
 * Iterative AES-128 encryption core
 * One load cycle with round key 0, then one round per clock
 * Round keys are expanded on the fly
 */
`timescale 1ns/1ps
`include "aes_wrap_config.svh"

module aes_cipher_core (
  input  logic                clk_i,
  input  logic                rst_ni,
  input  logic                start_i,
  input  aes_pkg::aes_key_t   key_i,
  input  aes_pkg::aes_state_u data_i,
  output aes_pkg::aes_state_u data_o,
  output logic                busy_o,
  output logic                valid_o
);

  localparam int unsigned NumRounds = `AES_NUM_ROUNDS;

  aes_pkg::aes_state_u state_q, rk_q;
  aes_pkg::aes_state_u shift_s, mix_s, rk_next;
  logic [7:0]  sb_out [16];
  logic [7:0]  ks_out [4];
  logic [31:0] rot_w, sub_w;
  logic [3:0]  round_q;
  logic [7:0]  rcon_q;
  logic        busy_q, valid_q, last_round, load;

  function automatic logic [7:0] xtime(input logic [7:0] b);
    return {b[6:0], 1'b0} ^ (b[7] ? 8'h1b : 8'h00);
  endfunction

  function automatic logic [31:0] mix_col(input logic [31:0] col);
    logic [7:0] a0, a1, a2, a3;
    a0 = col[31:24];
    a1 = col[23:16];
    a2 = col[15:8];
    a3 = col[7:0];
    return {xtime(a0) ^ xtime(a1) ^ a1 ^ a2 ^ a3,
            a0 ^ xtime(a1) ^ xtime(a2) ^ a2 ^ a3,
            a0 ^ a1 ^ xtime(a2) ^ xtime(a3) ^ a3,
            xtime(a0) ^ a0 ^ a1 ^ a2 ^ xtime(a3)};
  endfunction

  assign load       = start_i & ~busy_q;
  assign last_round = (round_q == 4'(NumRounds));

  // SubBytes on the state
  for (genvar i = 0; i < 16; i++) begin : g_state_sbox
    aes_sbox u_sbox (.byte_i(state_q.bytes[i]), .byte_o(sb_out[i]));
  end

  always_comb begin : shift_rows
    for (int c = 0; c < 4; c++) begin
      for (int r = 0; r < 4; r++) begin
        shift_s.bytes[4*c+r] = sb_out[4*((c+r)%4)+r];  // Row r rotates left by r
      end
    end
  end

  always_comb begin : mix_columns
    for (int c = 0; c < 4; c++) begin
      mix_s.cols[c] = last_round ? shift_s.cols[c] : mix_col(shift_s.cols[c]);
    end
  end

  // Key schedule, RotWord of the last column
  assign rot_w = {rk_q.bytes[13], rk_q.bytes[14], rk_q.bytes[15], rk_q.bytes[12]};

  for (genvar i = 0; i < 4; i++) begin : g_key_sbox
    aes_sbox u_sbox (.byte_i(rot_w[31-8*i -: 8]), .byte_o(ks_out[i]));
  end

  assign sub_w = {ks_out[0], ks_out[1], ks_out[2], ks_out[3]};

  always_comb begin : key_expand
    rk_next.cols[0] = rk_q.cols[0] ^ sub_w ^ {rcon_q, 24'h0};
    rk_next.cols[1] = rk_q.cols[1] ^ rk_next.cols[0];
    rk_next.cols[2] = rk_q.cols[2] ^ rk_next.cols[1];
    rk_next.cols[3] = rk_q.cols[3] ^ rk_next.cols[2];
  end

  // Round control; busy spans load plus ten rounds
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      busy_q  <= 1'b0;
      valid_q <= 1'b0;
      round_q <= '0;
      rcon_q  <= 8'h01;
    end else if (load) begin
      busy_q  <= 1'b1;
      round_q <= 4'd1;
      rcon_q  <= 8'h01;
    end else if (busy_q) begin
      round_q <= round_q + 4'd1;
      rcon_q  <= xtime(rcon_q);
      valid_q <= last_round;                        // Pulse with the final state
      busy_q  <= (round_q != 4'(NumRounds + 1));
    end else begin
      valid_q <= 1'b0;
    end
  end

  always_ff @(posedge clk_i) begin
    if (load) begin
      state_q <= data_i ^ key_i;  // AddRoundKey with round key 0
      rk_q    <= key_i;
    end else if (busy_q && round_q <= 4'(NumRounds)) begin
      state_q <= mix_s ^ rk_next;
      rk_q    <= rk_next;
    end
  end

  assign data_o  = state_q;
  assign busy_o  = busy_q;
  assign valid_o = valid_q;

endmodule

//--- aes/aes_sbox.sv
/*
 * AES forward S-box for one byte
 * GF(2^8) inverse by exponentiation, then affine map
 */
`timescale 1ns/1ps

module aes_sbox (
  input  logic [7:0] byte_i,
  output logic [7:0] byte_o
);

  logic [7:0] x2, x3, x12, x15, x60, x240, inv;

  // Multiply modulo x^8 + x^4 + x^3 + x + 1
  function automatic logic [7:0] gf_mul(input logic [7:0] a, input logic [7:0] b);
    logic [7:0] p;
    logic [7:0] x;
    p = '0;
    x = a;
    for (int i = 0; i < 8; i++) begin
      if (b[i]) p = p ^ x;
      x = {x[6:0], 1'b0} ^ (x[7] ? 8'h1b : 8'h00);
    end
    return p;
  endfunction

  // a^254 is the inverse, and 0 maps to 0
  assign x2   = gf_mul(byte_i, byte_i);
  assign x3   = gf_mul(x2, byte_i);
  assign x12  = gf_mul(gf_mul(x3, x3), gf_mul(x3, x3));  // (x^6)^2
  assign x15  = gf_mul(x12, x3);
  assign x60  = gf_mul(gf_mul(x15, x15), gf_mul(x15, x15));  // (x^30)^2
  assign x240 = gf_mul(gf_mul(x60, x60), gf_mul(x60, x60));  // (x^120)^2
  assign inv  = gf_mul(gf_mul(x240, x12), x2);

  // Affine map with constant 0x63
  assign byte_o = inv ^ {inv[6:0], inv[7]} ^ {inv[5:0], inv[7:6]} ^
                  {inv[4:0], inv[7:5]} ^ {inv[3:0], inv[7:4]} ^ 8'h63;

endmodule

//--- aes_fi_wrap.f
+incdir+common
common/aes_pkg.sv
common/aes_reg_pkg.sv
common/apb_if.sv
aes/aes_sbox.sv
aes/aes_cipher_core.sv
hdl/aes_reg_block.sv
hdl/aes_host_seq.sv
hdl/aes_fi_wrap.sv
testbench/tb_clk_gen.sv
testbench/aes_fi_wrap_checker.sv
testbench/tb_aes_fi_wrap.sv

//--- common/aes_pkg.sv
/*
 * Cipher data types
 * State union with byte and column views, key type
 */
`include "aes_wrap_config.svh"

package aes_pkg;

  // FIPS-197 order: byte 0 sits in the most significant bits,
  // column c holds bytes 4c to 4c+3
  typedef union packed {
    logic [0:`AES_BLOCK_W/8-1][7:0]             bytes;  // SubBytes, ShiftRows
    logic [0:`AES_BLOCK_W/`AES_DATA_W-1][31:0]  cols;   // MixColumns, AddRoundKey
  } aes_state_u;

  typedef logic [`AES_KEY_W-1:0] aes_key_t;

endpackage

//--- common/aes_reg_pkg.sv
/*
 * Register map types
 * CTRL and STATUS layouts, register address
 */
`include "aes_wrap_config.svh"

package aes_reg_pkg;

  typedef logic [`APB_ADDR_W-1:0] reg_addr_t;

  // Shadowed control word
  typedef struct packed {
    logic [`AES_DATA_W-11:0] reserved;  // 31:10
    logic                    sideload;  // Key comes from the sideload port
    logic [2:0]              key_len;
    logic [5:0]              mode;
  } ctrl_reg_t;

  // Status word, field positions follow the bit defines
  typedef struct packed {
    logic [`AES_DATA_W-1:`AES_STATUS_OUT_VALID_BIT+2]          reserved_hi;
    logic                                                      input_ready;
    logic                                                      output_valid;
    logic [`AES_STATUS_OUT_VALID_BIT-1:`AES_STATUS_IDLE_BIT+1] reserved_lo;
    logic                                                      idle;
  } status_reg_t;

endpackage

//--- common/aes_wrap_config.svh
/*
 * Shared widths, round count and register map of the AES wrapper
 * CTRL field encodings and STATUS bit positions
 */
`ifndef AES_WRAP_CONFIG_SVH
`define AES_WRAP_CONFIG_SVH

`define AES_DATA_W      32
`define AES_BLOCK_W     128
`define AES_KEY_W       128
`define AES_NUM_ROUNDS  10
`define APB_ADDR_W      8

// Register offsets, data words are 4 bytes apart
`define AES_CTRL_OFFSET    8'h00
`define AES_STATUS_OFFSET  8'h04
`define AES_DATA_IN_BASE   8'h10
`define AES_DATA_OUT_BASE  8'h20

`define AES_MODE_ECB     6'b00_0001
`define AES_KEY_LEN_128  3'b001

`define AES_STATUS_IDLE_BIT       0
`define AES_STATUS_OUT_VALID_BIT  3

`endif

//--- common/apb_if.sv
/*
 * APB bus between the host sequencer and the register block
 */
`timescale 1ns/1ps
`include "aes_wrap_config.svh"

interface apb_if;
  aes_reg_pkg::reg_addr_t  paddr;
  logic                    psel;
  logic                    penable;
  logic                    pwrite;
  logic [`AES_DATA_W-1:0]  pwdata;
  logic [`AES_DATA_W-1:0]  prdata;
  logic                    pready;
  logic                    pslverr;

  modport master (output paddr, psel, penable, pwrite, pwdata,
                  input  prdata, pready, pslverr);
  modport slave  (input  paddr, psel, penable, pwrite, pwdata,
                  output prdata, pready, pslverr);
endinterface

//--- hdl/aes_fi_wrap.sv
/*
 * AES fault-injection wrapper top level
 * Host sequencer, APB register block and cipher core with sideloaded key
 */
`timescale 1ns/1ps
`include "aes_wrap_config.svh"

module aes_fi_wrap (
  input  logic                    clk_i,
  input  logic                    rst_ni,
  input  logic [`AES_BLOCK_W-1:0] data_in_i,
  input  aes_pkg::aes_key_t       key_i,
  output logic [`AES_BLOCK_W-1:0] data_out_o,
  output logic                    done_o
);

  aes_pkg::aes_state_u core_data, core_result;
  logic                core_start, core_busy, core_valid;

  apb_if apb ();

  aes_host_seq u_seq (
    .clk_i      (clk_i),
    .rst_ni     (rst_ni),
    .data_in_i  (data_in_i),
    .apb        (apb.master),
    .data_out_o (data_out_o),
    .done_o     (done_o)
  );

  aes_reg_block u_regs (
    .clk_i    (clk_i),
    .rst_ni   (rst_ni),
    .apb      (apb.slave),
    .start_o  (core_start),
    .data_o   (core_data),
    .result_i (core_result),
    .busy_i   (core_busy),
    .valid_i  (core_valid)
  );

  // Key goes straight to the core over the sideload path
  aes_cipher_core u_core (
    .clk_i   (clk_i),
    .rst_ni  (rst_ni),
    .start_i (core_start),
    .key_i   (key_i),
    .data_i  (core_data),
    .data_o  (core_result),
    .busy_o  (core_busy),
    .valid_o (core_valid)
  );

endmodule

//--- hdl/aes_host_seq.sv
/*
 * Host sequencer, APB master
 * Waits for idle, writes CTRL twice, feeds a block, reads the result
 */
`timescale 1ns/1ps
`include "aes_wrap_config.svh"

module aes_host_seq (
  input  logic                   clk_i,
  input  logic                   rst_ni,
  input  logic [`AES_BLOCK_W-1:0] data_in_i,
  apb_if.master                  apb,
  output logic [`AES_BLOCK_W-1:0] data_out_o,
  output logic                   done_o
);

  typedef enum logic [2:0] {
    S_POLL_IDLE,
    S_WR_CTRL,
    S_WR_DATA,
    S_POLL_DONE,
    S_RD_DATA,
    S_FINISH
  } seq_state_e;

  typedef enum logic [1:0] {PH_GAP, PH_SETUP, PH_ACCESS} apb_phase_e;

  seq_state_e                  state_q;
  apb_phase_e                  phase_q;
  aes_reg_pkg::ctrl_reg_t      ctrl_word;
  aes_reg_pkg::status_reg_t    status;
  logic [3:0][`AES_DATA_W-1:0] data_out_q;
  logic [1:0]                  word_q;
  logic                        ctrl_cnt_q, done_q, xfer_done;

  assign xfer_done = (phase_q == PH_ACCESS) & apb.pready;
  assign status    = apb.prdata;

  always_comb begin
    ctrl_word          = '0;
    ctrl_word.mode     = `AES_MODE_ECB;
    ctrl_word.key_len  = `AES_KEY_LEN_128;
    ctrl_word.sideload = 1'b1;
  end

  // Address and data follow the state, the phase gives the handshake
  always_comb begin : bus_drive
    apb.psel    = (phase_q != PH_GAP);
    apb.penable = (phase_q == PH_ACCESS);
    apb.pwrite  = 1'b0;
    apb.paddr   = `AES_STATUS_OFFSET;
    apb.pwdata  = '0;
    case (state_q)
      S_WR_CTRL: begin
        apb.pwrite = 1'b1;
        apb.paddr  = `AES_CTRL_OFFSET;
        apb.pwdata = ctrl_word;
      end
      S_WR_DATA: begin
        apb.pwrite = 1'b1;
        apb.paddr  = `AES_DATA_IN_BASE + {word_q, 2'b00};
        apb.pwdata = data_in_i[`AES_DATA_W*word_q +: `AES_DATA_W];
      end
      S_RD_DATA: apb.paddr = `AES_DATA_OUT_BASE + {word_q, 2'b00};
      default: ;
    endcase
  end

  // Setup, access, one idle cycle; no transfers once finished
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      phase_q <= PH_GAP;
    end else begin
      case (phase_q)
        PH_GAP:    if (state_q != S_FINISH) phase_q <= PH_SETUP;
        PH_SETUP:  phase_q <= PH_ACCESS;
        PH_ACCESS: if (apb.pready) phase_q <= PH_GAP;
        default:   phase_q <= PH_GAP;
      endcase
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q    <= S_POLL_IDLE;
      ctrl_cnt_q <= 1'b0;
      word_q     <= '0;
      done_q     <= 1'b0;
      data_out_q <= '0;
    end else if (xfer_done) begin
      case (state_q)
        S_POLL_IDLE: if (status.idle) begin
          state_q    <= S_WR_CTRL;
          ctrl_cnt_q <= 1'b0;
        end
        S_WR_CTRL: begin
          ctrl_cnt_q <= 1'b1;
          if (ctrl_cnt_q) state_q <= S_WR_DATA;  // Second write commits the shadow
        end
        S_WR_DATA: begin
          word_q <= word_q + 2'd1;
          if (word_q == 2'd3) state_q <= S_POLL_DONE;
        end
        S_POLL_DONE: if (status.idle && status.output_valid) state_q <= S_RD_DATA;
        S_RD_DATA: begin
          data_out_q[word_q] <= apb.prdata;
          word_q             <= word_q + 2'd1;
          if (word_q == 2'd3) begin
            state_q <= S_FINISH;
            done_q  <= 1'b1;
          end
        end
        default: state_q <= S_POLL_IDLE;
      endcase
    end
  end

  assign data_out_o = data_out_q;
  assign done_o     = done_q;

endmodule

//--- hdl/aes_reg_block.sv
/*
 * APB register block of the AES wrapper
 * Shadowed CTRL, STATUS, data-in and data-out words, start control
 */
`timescale 1ns/1ps
`include "aes_wrap_config.svh"

module aes_reg_block (
  input  logic                clk_i,
  input  logic                rst_ni,
  apb_if.slave                apb,
  output logic                start_o,
  output aes_pkg::aes_state_u data_o,
  input  aes_pkg::aes_state_u result_i,
  input  logic                busy_i,
  input  logic                valid_i
);

  aes_reg_pkg::reg_addr_t     word_base;
  aes_reg_pkg::ctrl_reg_t     ctrl_q, shadow_q, wr_ctrl;
  aes_reg_pkg::status_reg_t   status;
  logic [1:0]                 word_idx;
  logic [3:0][`AES_DATA_W-1:0] din_q, dout_q;
  logic                       wr_en, rd_en, ctrl_sel, din_sel, dout_sel;
  logic                       shadow_armed_q, start_q, out_valid_q, cfg_ok;

  // No wait states, no error responses
  assign apb.pready  = 1'b1;
  assign apb.pslverr = 1'b0;

  assign wr_en     = apb.psel & apb.penable & apb.pwrite;
  assign rd_en     = apb.psel & apb.penable & ~apb.pwrite;
  assign word_base = {apb.paddr[`APB_ADDR_W-1:4], 4'h0};
  assign word_idx  = apb.paddr[3:2];
  assign ctrl_sel  = (apb.paddr == `AES_CTRL_OFFSET);
  assign din_sel   = (word_base == `AES_DATA_IN_BASE);
  assign dout_sel  = (word_base == `AES_DATA_OUT_BASE);
  assign wr_ctrl   = apb.pwdata;

  // Only ECB with a sideloaded 128-bit key may run
  assign cfg_ok = (ctrl_q.mode == `AES_MODE_ECB) && (ctrl_q.key_len == `AES_KEY_LEN_128) &&
                  ctrl_q.sideload;

  always_comb begin
    status              = '0;
    status.idle         = ~busy_i & ~start_q;
    status.input_ready  = ~busy_i;
    status.output_valid = out_valid_q;
  end

  always_comb begin : read_mux
    apb.prdata = '0;
    if (ctrl_sel) begin
      apb.prdata = ctrl_q;
    end else if (apb.paddr == `AES_STATUS_OFFSET) begin
      apb.prdata = status;
    end else if (dout_sel) begin
      apb.prdata = dout_q[word_idx];
    end
  end

  // CTRL commits on the second of two matching writes in a row
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      ctrl_q         <= '0;
      shadow_q       <= '0;
      shadow_armed_q <= 1'b0;
    end else if (wr_en && ctrl_sel) begin
      if (shadow_armed_q && (wr_ctrl == shadow_q)) begin
        ctrl_q         <= wr_ctrl;
        shadow_armed_q <= 1'b0;
      end else begin
        shadow_q       <= wr_ctrl;  // Mismatch starts a new pair
        shadow_armed_q <= 1'b1;
      end
    end else if (wr_en) begin
      shadow_armed_q <= 1'b0;
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      start_q     <= 1'b0;
      out_valid_q <= 1'b0;
    end else begin
      start_q <= wr_en & din_sel & (word_idx == 2'd3) & cfg_ok;
      if (valid_i) begin
        out_valid_q <= 1'b1;
      end else if (rd_en && dout_sel && word_idx == 2'd3) begin
        out_valid_q <= 1'b0;  // Last word collected
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (wr_en && din_sel) din_q[word_idx] <= apb.pwdata;
    if (valid_i) dout_q <= result_i;
  end

  assign start_o = start_q;
  assign data_o  = din_q;

endmodule

//--- testbench/aes_fi_wrap_checker.sv
/*
 * Concurrent assertions on the AES wrapper
 * Core start, busy and valid timing, reset values, done and result hold
 * Bound to the top level
 */
`timescale 1ns/1ps
`include "aes_wrap_config.svh"

module aes_fi_wrap_checker (
  input logic                    clk_i,
  input logic                    rst_ni,
  input logic                    start_i,
  input logic                    busy_i,
  input logic                    valid_i,
  input logic                    done_i,
  input logic [`AES_BLOCK_W-1:0] data_out_i
);

  localparam int core_latency = `AES_NUM_ROUNDS + 1;  // Load cycle plus ten rounds

  int unsigned err_count = 0;

  a_core_latency: assert property (@(posedge clk_i) disable iff (!rst_ni)
      start_i |-> ##(core_latency) valid_i)
    else begin
      $error("Core valid did not follow start after %0d cycles", core_latency);
      err_count++;
    end

  a_busy_span: assert property (@(posedge clk_i) disable iff (!rst_ni)
      start_i |=> busy_i [*core_latency] ##1 !busy_i)
    else begin
      $error("Core busy did not span the load and the rounds");
      err_count++;
    end

  // Start only reaches an idle core
  a_start_idle: assert property (@(posedge clk_i) disable iff (!rst_ni)
      start_i |-> !busy_i)
    else begin
      $error("Core start while busy");
      err_count++;
    end

  a_pulses: assert property (@(posedge clk_i) disable iff (!rst_ni)
      (start_i |=> !start_i) and (valid_i |=> !valid_i))
    else begin
      $error("Start or valid held longer than one cycle");
      err_count++;
    end

  a_reset_values: assert property (@(posedge clk_i)
      !rst_ni |-> !done_i && data_out_i == '0)
    else begin
      $error("Outputs not cleared in reset");
      err_count++;
    end

  a_done_hold: assert property (@(posedge clk_i) disable iff (!rst_ni)
      done_i |=> done_i && $stable(data_out_i))
    else begin
      $error("done_o dropped or data_out_o changed before reset");
      err_count++;
    end

endmodule

bind aes_fi_wrap aes_fi_wrap_checker u_chk (
  .clk_i      (clk_i),
  .rst_ni     (rst_ni),
  .start_i    (core_start),
  .busy_i     (core_busy),
  .valid_i    (core_valid),
  .done_i     (done_o),
  .data_out_i (data_out_o)
);

//--- testbench/tb_aes_fi_wrap.sv
/*
 * Testbench of the AES wrapper
 * FIPS-197 known-answer runs, mid-run reset abort, watchdog
 */
`timescale 1ns/1ps
`include "aes_wrap_config.svh"

module tb_aes_fi_wrap;

  localparam int clk_period_ns = 4;
  localparam int num_runs      = 4;
  localparam int run_cycles    = 400;  // Bound per run including resets

  logic                    clk, por_n, abort_rst_n, rst_n, done;
  logic [`AES_BLOCK_W-1:0] data_in, data_out;
  aes_pkg::aes_key_t       key;

  assign rst_n = por_n & abort_rst_n;

  tb_clk_gen #(.period_ns(clk_period_ns), .reset_cycles(4)) u_clk (
    .clk_o  (clk),
    .rst_no (por_n)
  );

  aes_fi_wrap dut0 (
    .clk_i      (clk),
    .rst_ni     (rst_n),
    .data_in_i  (data_in),
    .key_i      (key),
    .data_out_o (data_out),
    .done_o     (done)
  );

  task automatic finish_failed(input string reason);
    $display("%s", reason);
    $display("Result: FAILED");
    $fatal(1, "Simulation stopped on the first error");
  endtask

  task automatic report_mismatch(input string what);
    finish_failed($sformatf("MISMATCH at %0d ns: %s", $time, what));
  endtask

  task automatic check_reset_state(input string when);
    assert (done == 1'b0) else report_mismatch($sformatf("done_o high %s", when));
    assert (data_out == '0)
      else report_mismatch($sformatf("data_out_o %h %s, expected zero", data_out, when));
  endtask

  task automatic wait_power_on;
    @(negedge clk);
    while (!rst_n) begin
      check_reset_state("during power-on reset");
      @(negedge clk);
    end
    check_reset_state("in the first cycle after reset");
  endtask

  // Called on a falling edge
  task automatic pulse_reset(input int cycles);
    abort_rst_n = 1'b0;
    repeat (cycles) begin
      @(negedge clk);
      check_reset_state("during reset");
    end
    abort_rst_n = 1'b1;
    @(negedge clk);
    check_reset_state("in the first cycle after reset");
  endtask

  task automatic run_vector(input aes_pkg::aes_key_t k, input logic [`AES_BLOCK_W-1:0] pt,
                            input logic [`AES_BLOCK_W-1:0] ct);
    int cycles;
    key     = k;
    data_in = pt;
    cycles  = 0;
    while (!done && cycles < run_cycles) begin
      @(negedge clk);
      cycles++;
    end
    if (!done) finish_failed($sformatf("done_o did not rise within %0d cycles", run_cycles));
    assert (data_out == ct)
      else report_mismatch($sformatf("data_out_o %h, expected %h", data_out, ct));
  endtask

  // Result must stay put while done_o is high
  task automatic check_hold(input int cycles);
    logic [`AES_BLOCK_W-1:0] held;
    held = data_out;
    repeat (cycles) begin
      @(negedge clk);
      assert (done == 1'b1) else report_mismatch("done_o dropped before reset");
      assert (data_out == held)
        else report_mismatch($sformatf("data_out_o changed to %h, held %h", data_out, held));
    end
  endtask

  initial begin : stimulus
    int unsigned abort_cycle;
    void'($urandom(58733));
    abort_rst_n = 1'b1;
    data_in     = '0;
    key         = '0;
    wait_power_on();

    run_vector(128'h000102030405060708090a0b0c0d0e0f, 128'h00112233445566778899aabbccddeeff,
               128'h69c4e0d86a7b0430d8cdb78070b4c55a);
    check_hold(16);
    pulse_reset(4);

    run_vector(128'h2b7e151628aed2a6abf7158809cf4f3c, 128'h3243f6a8885a308d313198a2e0370734,
               128'h3925841d02dc09fbdc118597196a0b32);
    check_hold(16);
    pulse_reset(4);

    // Abort a run part way before the result is read back
    key         = 128'h000102030405060708090a0b0c0d0e0f;
    data_in     = 128'h00112233445566778899aabbccddeeff;
    abort_cycle = $urandom_range(40, 4);
    repeat (abort_cycle) @(negedge clk);
    pulse_reset(3);

    run_vector(128'h2b7e151628aed2a6abf7158809cf4f3c, 128'h3243f6a8885a308d313198a2e0370734,
               128'h3925841d02dc09fbdc118597196a0b32);
    check_hold(16);

    if (dut0.u_chk.err_count == 0) begin
      $display("Result: PASSED");
      $finish;
    end else begin
      finish_failed("A concurrent assertion in the checker failed");
    end
  end

  always @(negedge clk) begin
    if (dut0.u_chk.err_count != 0) finish_failed("A concurrent assertion in the checker failed");
  end

  initial begin : watchdog
    #(num_runs * run_cycles * clk_period_ns);
    finish_failed($sformatf("Timeout: the test did not end within %0d cycles",
                            num_runs * run_cycles));
  end

endmodule

//--- testbench/tb_clk_gen.sv
/*
 * Testbench clock and power-on reset
 */
`timescale 1ns/1ps

module tb_clk_gen #(
  parameter int period_ns    = 4,
  parameter int reset_cycles = 4
) (
  output logic clk_o,
  output logic rst_no
);

  initial begin
    clk_o = 1'b0;
    forever #(period_ns / 2.0) clk_o = ~clk_o;
  end

  // Release lands on a falling edge, like every other input
  initial begin
    rst_no = 1'b0;
    repeat (reset_cycles) @(posedge clk_o);
    @(negedge clk_o);
    rst_no <= 1'b1;
  end

endmodule
